// File: src/arm_exec_params.svh
// Sizing for the execute core; ARM_REG_ADDR_W has to stay log2 of ARM_REG_COUNT
`ifndef ARM_EXEC_PARAMS_SVH
`define ARM_EXEC_PARAMS_SVH

// Datapath, register and result width
`define ARM_DATA_W 32

// Architectural registers, R15 is an ordinary register here
`define ARM_REG_COUNT 16

// Register index width
`define ARM_REG_ADDR_W 4

// Operand field instr[11:0]
`define ARM_OPND_W 12

`endif

// File: src/arm_exec_pkg.sv
// Types shared by the execute core; opcodes 4 to 15 exist in alu_op_e only as undefined codes
`default_nettype none

`include "arm_exec_params.svh"

package arm_exec_pkg;

  typedef enum logic [3:0] {
    AND = 4'd0,
    OR  = 4'd1,
    SUB = 4'd2,
    ADD = 4'd3
  } alu_op_e;

  typedef enum logic [1:0] {
    ROT_IMM   = 2'd0,  // imm8 rotated right by 2*count
    REG       = 2'd1,
    IMM12     = 2'd2,  // Zero-extended operand field
    SHIFT_REG = 2'd3
  } addr_mode_e;

  typedef enum logic [1:0] {
    LSL = 2'd0,
    LSR = 2'd1,
    ASR = 2'd2,
    ROR = 2'd3
  } shift_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;  // Carry on ADD, borrow on SUB
    logic v;
  } flags_t;

  typedef struct packed {
    logic                       valid;
    logic                       wr_en;
    addr_mode_e                 mode;
    alu_op_e                    op;
    logic                       set_flags;
    logic [`ARM_REG_ADDR_W-1:0] rn;
    logic [`ARM_REG_ADDR_W-1:0] rd;
    logic [`ARM_OPND_W-1:0]     opnd;  // Rm sits in the low 4 bits
  } decoded_t;

  typedef struct packed {
    logic                       valid;  // Result is written to rd
    logic [`ARM_REG_ADDR_W-1:0] rd;
    logic [`ARM_DATA_W-1:0]     data;
  } wb_t;

endpackage

`default_nettype wire

// File: src/instr_decoder.sv
// Input register of the core; instr[31:28] are ignored and every strobed word is accepted
`default_nettype none

module instr_decoder import arm_exec_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  output decoded_t    decoded
);

  decoded_t fields;

  // Field split of the incoming word
  always_comb begin
    fields.valid     = instr_valid;  // No strobe gives a bubble
    fields.wr_en     = instr[27];
    fields.mode      = addr_mode_e'(instr[26:25]);
    fields.op        = alu_op_e'(instr[24:21]);  // Undefined codes pass unchanged
    fields.set_flags = instr[20];
    fields.rn        = instr[19:16];
    fields.rd        = instr[15:12];
    fields.opnd      = instr[11:0];
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      decoded <= '0;
    end else begin
      decoded <= fields;
    end
  end

endmodule

`default_nettype wire

// File: src/register_file.sv
// 16x32 register file, reset to zero; a same-cycle write is bypassed to both read ports
`default_nettype none

`include "arm_exec_params.svh"

module register_file import arm_exec_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`ARM_REG_ADDR_W-1:0] rn,
  input  logic [`ARM_REG_ADDR_W-1:0] rm,
  input  wb_t                        wb,
  output logic [`ARM_DATA_W-1:0]     rn_data,
  output logic [`ARM_DATA_W-1:0]     rm_data
);

  logic [`ARM_DATA_W-1:0] regs [`ARM_REG_COUNT];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `ARM_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Write-through covers the writeback to execute hazard
  assign rn_data = (wb.valid && (wb.rd == rn)) ? wb.data : regs[rn];
  assign rm_data = (wb.valid && (wb.rd == rm)) ? wb.data : regs[rm];

endmodule

`default_nettype wire

// File: src/operand_shifter.sv
// Second ALU operand; unlike real ARM, a shift amount of 0 passes Rm through for every shift type
`default_nettype none

`include "arm_exec_params.svh"

module operand_shifter import arm_exec_pkg::*; (
  input  addr_mode_e             mode,
  input  logic [`ARM_OPND_W-1:0] opnd,
  input  logic [`ARM_DATA_W-1:0] rm_data,
  output logic [`ARM_DATA_W-1:0] operand
);

  logic [`ARM_DATA_W-1:0] imm8;
  logic [4:0]             rot;
  logic [4:0]             shamt;
  shift_e                 shift;

  function automatic logic [`ARM_DATA_W-1:0] rotr(input logic [`ARM_DATA_W-1:0] value,
                                                  input logic [4:0]             amount);
    logic [2*`ARM_DATA_W-1:0] pair;
    pair = {value, value} >> amount;  // Low half holds the rotated word
    return pair[`ARM_DATA_W-1:0];
  endfunction

  assign imm8  = {{(`ARM_DATA_W-8){1'b0}}, opnd[7:0]};
  assign rot   = {opnd[11:8], 1'b0};  // Twice the 4-bit count
  assign shamt = opnd[11:7];
  assign shift = shift_e'(opnd[6:5]);

  always_comb begin
    case (mode)
      ROT_IMM: operand = rotr(imm8, rot);
      REG:     operand = rm_data;
      IMM12:   operand = {{(`ARM_DATA_W-`ARM_OPND_W){1'b0}}, opnd};
      default: begin
        case (shift)
          LSL:     operand = rm_data << shamt;
          LSR:     operand = rm_data >> shamt;
          ASR:     operand = $signed(rm_data) >>> shamt;  // Sign fill
          default: operand = rotr(rm_data, shamt);
        endcase
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/alu.sv
// Four-op ALU with flag register; undefined opcodes give 0 and, with set_flags, Z=1 and N=C=V=0
`default_nettype none

`include "arm_exec_params.svh"

module alu import arm_exec_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  decoded_t               decoded,
  input  logic [`ARM_DATA_W-1:0] a,
  input  logic [`ARM_DATA_W-1:0] b,
  output logic [`ARM_DATA_W-1:0] result,
  output flags_t                 flags
);

  localparam int MSB = `ARM_DATA_W - 1;

  logic [`ARM_DATA_W:0] sum;   // Carry-out in the top bit
  logic [`ARM_DATA_W:0] diff;  // Borrow in the top bit when a < b
  flags_t               next_flags;

  assign sum  = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} - {1'b0, b};

  always_comb begin
    next_flags = '0;  // Logic ops leave C and V clear
    case (decoded.op)
      AND: result = a & b;
      OR:  result = a | b;
      SUB: begin
        result       = diff[MSB:0];
        next_flags.c = diff[`ARM_DATA_W];
        // Operands of opposite sign and the sign of a is lost
        next_flags.v = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
      end
      ADD: begin
        result       = sum[MSB:0];
        next_flags.c = sum[`ARM_DATA_W];
        next_flags.v = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]);
      end
      default: result = '0;
    endcase
    next_flags.n = result[MSB];
    next_flags.z = (result == '0);
  end

  // Flags only move on a valid instruction that asks for them
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags <= '0;
    end else if (decoded.valid && decoded.set_flags) begin
      flags <= next_flags;
    end
  end

endmodule

`default_nettype wire

// File: src/writeback_stage.sv
// Output register of the core; result data and rd are captured every cycle, valid marks a write
`default_nettype none

`include "arm_exec_params.svh"

module writeback_stage import arm_exec_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  decoded_t               decoded,
  input  logic [`ARM_DATA_W-1:0] result,
  output wb_t                    wb
);

  wb_t wb_next;

  always_comb begin
    wb_next.valid = decoded.valid && decoded.wr_en;  // Bubbles and no-write ops drop out
    wb_next.rd    = decoded.rd;
    wb_next.data  = result;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb <= '0;
    end else begin
      wb <= wb_next;
    end
  end

endmodule

`default_nettype wire

// File: src/arm_exec_core.sv
// Execute core top; one instruction per strobe, result and flags two edges after the drive edge
`default_nettype none

`include "arm_exec_params.svh"

module arm_exec_core import arm_exec_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  output wb_t         result,
  output flags_t      flags
);

  decoded_t               decoded;
  logic [`ARM_DATA_W-1:0] rn_data;
  logic [`ARM_DATA_W-1:0] rm_data;
  logic [`ARM_DATA_W-1:0] operand;
  logic [`ARM_DATA_W-1:0] alu_result;

  instr_decoder u_decoder (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .decoded     (decoded)
  );

  // Write port driven straight from the output register
  register_file u_regfile (
    .clk     (clk),
    .reset   (reset),
    .rn      (decoded.rn),
    .rm      (decoded.opnd[`ARM_REG_ADDR_W-1:0]),  // Rm field
    .wb      (result),
    .rn_data (rn_data),
    .rm_data (rm_data)
  );

  operand_shifter u_shifter (
    .mode    (decoded.mode),
    .opnd    (decoded.opnd),
    .rm_data (rm_data),
    .operand (operand)
  );

  alu u_alu (
    .clk     (clk),
    .reset   (reset),
    .decoded (decoded),
    .a       (rn_data),
    .b       (operand),
    .result  (alu_result),
    .flags   (flags)
  );

  writeback_stage u_writeback (
    .clk     (clk),
    .reset   (reset),
    .decoded (decoded),
    .result  (alu_result),
    .wb      (result)
  );

endmodule

`default_nettype wire

// File: testbench/tb_arm_exec_core.sv
// Self-checking testbench; a result is expected two edges after its drive edge, first mismatch ends the run
`default_nettype none

`include "arm_exec_params.svh"

module tb_arm_exec_core import arm_exec_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_RANDOM     = 2000;
  localparam int DIRECTED_STEPS = 100;  // Bound on the directed tests and the flush
  localparam int MAX_CYCLES     = 10 + DIRECTED_STEPS + 2 * NUM_RANDOM + 100;  // One bubble max per op
  localparam longint S_MAX      = 64'sd2147483647;
  localparam longint S_MIN      = -64'sd2147483648;

  typedef struct packed {
    int     due;    // Step at which the DUT shows this entry
    wb_t    wb;
    flags_t flags;
  } expect_t;

  logic        clk;
  logic        reset;
  logic        instr_valid;
  logic [31:0] instr;
  wb_t         result;
  flags_t      flags;

  logic [31:0] model_regs [`ARM_REG_COUNT];
  flags_t      model_flags;
  expect_t     exp_q[$];
  int          step_idx    = 0;
  int          cycle_count = 0;
  string       test_name;

  arm_exec_core u_dut (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .result      (result),
    .flags       (flags)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("tests failed");
      $fatal(1, "Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    end
  end

  function automatic logic [31:0] make_instr(input logic wr, input logic [1:0] mode,
                                             input logic [3:0] op, input logic s,
                                             input logic [3:0] rn, input logic [3:0] rd,
                                             input logic [11:0] opnd);
    return {4'd0, wr, mode, op, s, rn, rd, opnd};
  endfunction

  function automatic logic [11:0] shift_field(input logic [4:0] amount, input logic [1:0] kind,
                                              input logic [3:0] rm);
    return {amount, kind, 1'b0, rm};
  endfunction

  function automatic logic [31:0] rotate_right(input logic [31:0] x, input int amount);
    if (amount == 0) return x;
    return (x >> amount) | (x << (32 - amount));
  endfunction

  function automatic logic [31:0] arith_shift_right(input logic [31:0] x, input int amount);
    logic [31:0] res;
    res = x;
    for (int i = 0; i < amount; i++) res = {res[31], res[31:1]};  // Copy the sign bit in
    return res;
  endfunction

  // Second operand by addressing mode
  function automatic logic [31:0] model_operand(input logic [1:0] mode, input logic [11:0] opnd,
                                                input logic [31:0] rm_val);
    int          amount;
    logic [31:0] value;
    amount = int'(opnd[11:7]);
    case (mode)
      2'd0: value = rotate_right({24'd0, opnd[7:0]}, 2 * int'(opnd[11:8]));
      2'd1: value = rm_val;
      2'd2: value = {20'd0, opnd};
      default: begin
        case (opnd[6:5])
          2'd0:    value = rm_val << amount;
          2'd1:    value = rm_val >> amount;
          2'd2:    value = arith_shift_right(rm_val, amount);
          default: value = rotate_right(rm_val, amount);
        endcase
      end
    endcase
    return value;
  endfunction

  // Executes one issued word on the model, in issue order
  task automatic model_apply(input logic valid, input logic [31:0] word, output expect_t e);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    longint      wide;
    flags_t      next;
    a = model_regs[word[19:16]];
    b = model_operand(word[26:25], word[11:0], model_regs[word[3:0]]);
    next = '0;
    case (word[24:21])
      4'd0: res = a & b;
      4'd1: res = a | b;
      4'd2: begin
        res    = a - b;
        next.c = (a < b);  // Borrow
        wide   = longint'($signed(a)) - longint'($signed(b));
        next.v = (wide > S_MAX) || (wide < S_MIN);
      end
      4'd3: begin
        res    = a + b;
        next.c = (longint'(a) + longint'(b)) > 64'sd4294967295;
        wide   = longint'($signed(a)) + longint'($signed(b));
        next.v = (wide > S_MAX) || (wide < S_MIN);
      end
      default: res = '0;
    endcase
    next.n = res[31];
    next.z = (res == 32'd0);
    if (valid && word[20]) model_flags = next;
    e.due      = step_idx + 2;
    e.wb.valid = valid && word[27];
    e.wb.rd    = word[15:12];
    e.wb.data  = res;
    e.flags    = model_flags;
    if (e.wb.valid) model_regs[word[15:12]] = res;
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
      $display("tests failed");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic check_entry(input expect_t e);
    check_value("result.valid", 32'(e.wb.valid), 32'(result.valid));
    if (e.wb.valid) begin  // rd and data only mean something on a write
      check_value("result.rd", 32'(e.wb.rd), 32'(result.rd));
      check_value("result.data", e.wb.data, result.data);
    end
    check_value("flags", 32'(e.flags), 32'(flags));
  endtask

  task automatic advance();
    expect_t e;
    @(negedge clk);
    if (exp_q.size() > 0 && exp_q[0].due == step_idx) begin
      e = exp_q.pop_front();
      check_entry(e);
    end
    step_idx++;
  endtask

  task automatic issue(input logic valid, input logic [31:0] word);
    expect_t e;
    @(posedge clk);
    instr_valid <= valid;
    instr       <= word;
    model_apply(valid, word, e);
    exp_q.push_back(e);
    advance();
  endtask

  task automatic flush_pipeline();
    repeat (2) begin
      @(posedge clk);
      instr_valid <= 1'b0;
      instr       <= '0;
      advance();
    end
  endtask

  task automatic reg_op(input logic [3:0] op, input logic [3:0] rd, input logic [3:0] rn,
                        input logic [3:0] rm);
    issue(1'b1, make_instr(1'b1, REG, op, 1'b1, rn, rd, {8'd0, rm}));
  endtask

  initial begin
    logic [3:0]  rd;
    logic [3:0]  rn;
    logic [3:0]  prev_rd;
    logic [1:0]  mode;
    logic [11:0] opnd;
    int          seed_val;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    model_flags = '0;
    for (int i = 0; i < `ARM_REG_COUNT; i++) model_regs[i] = '0;
    seed_val = $urandom(32'hccc6);
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);

    test_name = "reset";
    check_value("result.valid", 32'd0, 32'(result.valid));
    check_value("flags", 32'd0, 32'(flags));
    reg_op(ADD, 4'd1, 4'd0, 4'd0);  // 0 + 0 sets Z only

    test_name = "immediate_load";
    for (int r = 1; r < 16; r++) begin
      mode = (r % 2 == 1) ? ROT_IMM : IMM12;
      issue(1'b1, make_instr(1'b1, mode, ADD, 1'b0, 4'd0, 4'(r), 12'($urandom())));
    end
    issue(1'b1, make_instr(1'b1, IMM12, ADD, 1'b0, 4'd0, 4'd0, 12'($urandom())));
    for (int r = 0; r < 16; r++) reg_op(OR, 4'(r), 4'(r), 4'(r));  // Readback

    test_name = "flag_extremes";
    issue(1'b1, make_instr(1'b1, IMM12, AND, 1'b1, 4'd0, 4'd0, 12'd0));  // R0 = 0
    issue(1'b1, make_instr(1'b1, IMM12, ADD, 1'b1, 4'd0, 4'd1, 12'd1));  // R1 = 1
    reg_op(SUB, 4'd2, 4'd0, 4'd1);  // 0 - 1 borrows
    issue(1'b1, make_instr(1'b1, SHIFT_REG, ADD, 1'b1, 4'd0, 4'd3, shift_field(5'd1, LSR, 4'd2)));
    reg_op(ADD, 4'd4, 4'd3, 4'd1);  // Positive overflow
    reg_op(ADD, 4'd5, 4'd2, 4'd1);  // Carry out, zero
    reg_op(ADD, 4'd6, 4'd4, 4'd4);  // Negative overflow
    reg_op(SUB, 4'd7, 4'd4, 4'd1);
    reg_op(SUB, 4'd8, 4'd3, 4'd2);
    reg_op(SUB, 4'd9, 4'd1, 4'd1);
    issue(1'b1, make_instr(1'b1, SHIFT_REG, ADD, 1'b1, 4'd0, 4'd10, shift_field(5'd4, ASR, 4'd4)));

    test_name = "dependent_chain";
    prev_rd = 4'd1;
    for (int i = 0; i < 24; i++) begin
      rd   = 4'($urandom_range(15, 0));
      rn   = (i % 3 == 0) ? 4'($urandom_range(15, 0)) : prev_rd;
      mode = (i % 2 == 0) ? REG : SHIFT_REG;
      opnd = (i % 2 == 0) ? {8'd0, prev_rd} : shift_field(5'($urandom()), 2'($urandom()), prev_rd);
      issue(1'b1, make_instr(1'b1, mode, 4'($urandom_range(3, 0)), 1'($urandom()), rn, rd, opnd));
      prev_rd = rd;
    end

    test_name = "random";
    for (int i = 0; i < NUM_RANDOM; i++) begin
      if ($urandom_range(3, 0) == 0) issue(1'b0, $urandom());
      issue(1'b1, $urandom());
    end
    flush_pipeline();

    if (exp_q.size() == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1, "%0d expected results never appeared", exp_q.size());
    end
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+src
src/arm_exec_pkg.sv
src/instr_decoder.sv
src/register_file.sv
src/operand_shifter.sv
src/alu.sv
src/writeback_stage.sv
src/arm_exec_core.sv
testbench/tb_arm_exec_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timescale 1ns/1ps -j 0
TOP       ?= tb_arm_exec_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The exit status of the simulation is the test result
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
